//--- nabp_pkg.sv
`default_nettype none

package nabp_pkg;

    // filtered sample width
    localparam int kFilteredDataLength = 16;

    // samples in one projection line
    localparam int kLineSize = 64;

    // detector index width, covers 0 to kLineSize-1
    localparam int kSLength = $clog2(kLineSize);

    // host filter order, the source index runs ahead by half of it
    localparam int kFilterOrder = 8;

    // swappable banks, 3 or 4 also work
    localparam int kNumBanks = 2;
    localparam int kBankSelLength = $clog2(kNumBanks);

    // one reader per RAM port
    localparam int kNumReaders = 2;

    typedef logic [kSLength-1:0] s_val_t;
    typedef logic signed [kFilteredDataLength-1:0] filtered_val_t;
    typedef logic [kBankSelLength-1:0] bank_sel_t;

    // filler write command, seen by every bank
    typedef struct packed {
        logic          we;
        bank_sel_t     bank;
        s_val_t        s;
        filtered_val_t val;
    } bank_write_t;

endpackage

`default_nettype wire

//--- dual_port_ram.sv
`default_nettype none

module dual_port_ram
(
    input  wire                     clk,
    // port 0 reads and writes
    input  wire                     we_0,
    input  wire nabp_pkg::s_val_t   addr_0,
    input  wire nabp_pkg::filtered_val_t data_in_0,
    // port 1 only reads
    input  wire nabp_pkg::s_val_t   addr_1,
    output nabp_pkg::filtered_val_t data_out_0,
    output nabp_pkg::filtered_val_t data_out_1
);

    // one projection line
    nabp_pkg::filtered_val_t mem [nabp_pkg::kLineSize];

    // port 0 returns the old word on a write
    always_ff @(posedge clk)
    begin
        if (we_0)
        begin
            mem[addr_0] <= data_in_0;
        end
        data_out_0 <= mem[addr_0];
    end

    always_ff @(posedge clk)
    begin
        data_out_1 <= mem[addr_1];
    end

endmodule

`default_nettype wire

//--- filtered_ram_bank.sv
`default_nettype none

module filtered_ram_bank
#(
    parameter int bank_index = 0
)
(
    input  wire                     clk,
    // broadcast write command from the filler
    input  wire nabp_pkg::bank_write_t wr,
    // reader indices
    input  wire nabp_pkg::s_val_t   rd_s_0,
    input  wire nabp_pkg::s_val_t   rd_s_1,
    // read data, one cycle after the index
    output nabp_pkg::filtered_val_t val_0,
    output nabp_pkg::filtered_val_t val_1
);

    logic             wr_hit;
    nabp_pkg::s_val_t addr_0;

    // this bank is the one being filled
    assign wr_hit = wr.we && (wr.bank == nabp_pkg::bank_sel_t'(bank_index));

    // filler owns port 0 while filling, reader 0 otherwise
    always_comb
    begin
        if (wr_hit)
        begin
            addr_0 = wr.s;
        end
        else
        begin
            addr_0 = rd_s_0;
        end
    end

    dual_port_ram u_ram
    (
        .clk        (clk),
        .we_0       (wr_hit),
        .addr_0     (addr_0),
        .data_in_0  (wr.val),
        .addr_1     (rd_s_1),
        .data_out_0 (val_0),
        .data_out_1 (val_1)
    );

endmodule

`default_nettype wire

//--- filtered_line_filler.sv
`default_nettype none

module filtered_line_filler
(
    input  wire                     clk,
    input  wire                     reset_n,
    // host side
    input  wire                     hs_fill_kick,
    input  wire nabp_pkg::filtered_val_t hs_val,
    output logic                    hs_fill_done,
    output nabp_pkg::s_val_t        hs_s_val,
    // bank side
    output nabp_pkg::bank_write_t   wr,
    output nabp_pkg::bank_sel_t     ready_bank
);

    typedef enum logic [1:0] {
        ready_s,
        delay_s,
        fill_s
    } state_t;

    state_t              state;
    state_t              next_state;
    nabp_pkg::s_val_t    read_itr;
    nabp_pkg::s_val_t    write_itr;
    nabp_pkg::bank_sel_t fill_bank;
    logic                delay_done;
    logic                line_last;

    // last delay cycle, read index has covered the filter lead
    assign delay_done = (read_itr == nabp_pkg::s_val_t'(nabp_pkg::kFilterOrder / 2 - 1));

    // last fill cycle of the line
    assign line_last = (state == fill_s) &&
                       (write_itr == nabp_pkg::s_val_t'(nabp_pkg::kLineSize - 1));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ready_s;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (hs_fill_kick)
                begin
                    next_state = delay_s;
                end
            delay_s:
                if (delay_done)
                begin
                    next_state = fill_s;
                end
            fill_s:
                if (line_last)
                begin
                    next_state = ready_s;
                end
            default:
                next_state = ready_s;
        endcase
    end

    // indices clear at line end so ready always shows 0
    always_ff @(posedge clk)
    begin
        if (!reset_n || line_last)
        begin
            read_itr  <= '0;
            write_itr <= '0;
        end
        else if (state == delay_s)
        begin
            read_itr <= read_itr + 1'b1;
        end
        else if (state == fill_s)
        begin
            write_itr <= write_itr + 1'b1;
            // source index holds at the last sample
            if (read_itr != nabp_pkg::s_val_t'(nabp_pkg::kLineSize - 1))
            begin
                read_itr <= read_itr + 1'b1;
            end
        end
    end

    // round-robin bank rotation at line end
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_bank  <= '0;
            ready_bank <= nabp_pkg::bank_sel_t'(nabp_pkg::kNumBanks - 1);
        end
        else if (line_last)
        begin
            ready_bank <= fill_bank;
            if (fill_bank == nabp_pkg::bank_sel_t'(nabp_pkg::kNumBanks - 1))
            begin
                fill_bank <= '0;
            end
            else
            begin
                fill_bank <= nabp_pkg::bank_sel_t'(fill_bank + 1'b1);
            end
        end
    end

    // mealy outputs
    assign hs_fill_done = line_last;
    assign hs_s_val     = read_itr;

    always_comb
    begin
        wr.we   = (state == fill_s);
        wr.bank = fill_bank;
        wr.s    = write_itr;
        wr.val  = hs_val;
    end

endmodule

`default_nettype wire

//--- processing_read_mux.sv
`default_nettype none

module processing_read_mux
(
    input  wire                     clk,
    input  wire                     reset_n,
    // most recently completed bank
    input  wire nabp_pkg::bank_sel_t ready_bank,
    // per-bank read data for reader 0 and reader 1
    input  wire nabp_pkg::filtered_val_t bank_val_0 [nabp_pkg::kNumBanks],
    input  wire nabp_pkg::filtered_val_t bank_val_1 [nabp_pkg::kNumBanks],
    output nabp_pkg::filtered_val_t pr_val [nabp_pkg::kNumReaders]
);

    // bank that was ready when the RAM sampled the address
    nabp_pkg::bank_sel_t rd_bank;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_bank <= nabp_pkg::bank_sel_t'(nabp_pkg::kNumBanks - 1);
        end
        else
        begin
            rd_bank <= ready_bank;
        end
    end

    // a swap only affects reads issued after it
    always_comb
    begin
        pr_val[0] = bank_val_0[rd_bank];
        pr_val[1] = bank_val_1[rd_bank];
    end

endmodule

`default_nettype wire

//--- nabp_filtered_line_top.sv
`default_nettype none

module nabp_filtered_line_top
(
    input  wire                     clk,
    input  wire                     reset_n,
    // host filter interface
    input  wire                     hs_fill_kick,
    input  wire nabp_pkg::filtered_val_t hs_val,
    output nabp_pkg::s_val_t        hs_s_val,
    output logic                    hs_fill_done,
    // processing readers
    input  wire nabp_pkg::s_val_t   pr_s_val [nabp_pkg::kNumReaders],
    output nabp_pkg::filtered_val_t pr_val [nabp_pkg::kNumReaders]
);

    nabp_pkg::bank_write_t   wr;
    nabp_pkg::bank_sel_t     ready_bank;
    nabp_pkg::filtered_val_t bank_val_0 [nabp_pkg::kNumBanks];
    nabp_pkg::filtered_val_t bank_val_1 [nabp_pkg::kNumBanks];

    filtered_line_filler u_filler
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .hs_fill_kick (hs_fill_kick),
        .hs_val       (hs_val),
        .hs_fill_done (hs_fill_done),
        .hs_s_val     (hs_s_val),
        .wr           (wr),
        .ready_bank   (ready_bank)
    );

    // every bank sees the write command and both reader indices
    for (genvar b = 0; b < nabp_pkg::kNumBanks; b++)
    begin : g_bank
        filtered_ram_bank
        #(
            .bank_index (b)
        )
        u_bank
        (
            .clk    (clk),
            .wr     (wr),
            .rd_s_0 (pr_s_val[0]),
            .rd_s_1 (pr_s_val[1]),
            .val_0  (bank_val_0[b]),
            .val_1  (bank_val_1[b])
        );
    end

    processing_read_mux u_read_mux
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .ready_bank (ready_bank),
        .bank_val_0 (bank_val_0),
        .bank_val_1 (bank_val_1),
        .pr_val     (pr_val)
    );

endmodule

`default_nettype wire

//--- tb_nabp_filtered_line.sv
`default_nettype none

module tb_nabp_filtered_line;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int lead = nabp_pkg::kFilterOrder / 2;
    localparam int fill_cycles = lead + nabp_pkg::kLineSize;
    localparam int timeout_cycles = 4 * fill_cycles;
    localparam int max_lines = 8;

    logic                    clk;
    logic                    reset_n;
    logic                    hs_fill_kick;
    nabp_pkg::filtered_val_t hs_val;
    nabp_pkg::s_val_t        hs_s_val;
    logic                    hs_fill_done;
    nabp_pkg::s_val_t        pr_s_val [nabp_pkg::kNumReaders];
    nabp_pkg::filtered_val_t pr_val [nabp_pkg::kNumReaders];

    // reference copy of every line sent through the host filter
    nabp_pkg::filtered_val_t lines [max_lines][nabp_pkg::kLineSize];
    int                      reads_per_line [max_lines];
    int                      fill_line;
    int                      view_line = -1;
    int                      error_count;
    int                      check_count;
    string                   test_name;

    // host filter delay line of source indices
    nabp_pkg::s_val_t        s_delay [lead];

    nabp_filtered_line_top DUT
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .hs_fill_kick (hs_fill_kick),
        .hs_val       (hs_val),
        .hs_s_val     (hs_s_val),
        .hs_fill_done (hs_fill_done),
        .pr_s_val     (pr_s_val),
        .pr_val       (pr_val)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        for (int i = 0; i < lead; i++)
        begin
            s_delay[i] = '0;
        end
    end

    // host filter model returning the value for the index seen lead cycles ago
    always @(negedge clk)
    begin
        hs_val = lines[fill_line][s_delay[lead-1]];
        for (int i = lead - 1; i > 0; i--)
        begin
            s_delay[i] = s_delay[i-1];
        end
        s_delay[0] = hs_s_val;
    end

    // line the readers see swaps at the edge that ends the last fill cycle
    always @(posedge clk)
    begin
        if (hs_fill_done)
        begin
            view_line <= fill_line;
        end
    end

    task automatic new_line_pattern(input int line);
        for (int s = 0; s < nabp_pkg::kLineSize; s++)
        begin
            lines[line][s] = nabp_pkg::filtered_val_t'($urandom);
        end
    endtask

    // kick is dropped again by the caller's wait loop
    task automatic start_fill(input int line);
        new_line_pattern(line);
        fill_line = line;
        @(negedge clk);
        hs_fill_kick = 1'b1;
    endtask

    task automatic wait_fill_done(output int cycles);
        logic done_seen;
        cycles = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < timeout_cycles)
        begin
            @(negedge clk);
            hs_fill_kick = 1'b0;
            cycles++;
            done_seen = hs_fill_done;
        end
        if (!done_seen)
        begin
            $display("%s: hs_fill_done never came within %0d cycles", test_name, cycles);
            error_count++;
        end
    endtask

    // reader 0 walks up and reader 1 walks down with one new read per cycle
    task automatic sweep_reads(input int num_reads);
        nabp_pkg::s_val_t        addr_0;
        nabp_pkg::s_val_t        addr_1;
        nabp_pkg::filtered_val_t exp_0;
        nabp_pkg::filtered_val_t exp_1;
        int                      line_used;
        line_used = -1;
        addr_0 = '0;
        addr_1 = '0;
        for (int i = 0; i <= num_reads; i++)
        begin
            @(negedge clk);
            if (i > 0 && line_used < 0)
            begin
                $display("%s: read issued before any line was filled", test_name);
                error_count++;
            end
            else if (i > 0)
            begin
                exp_0 = lines[line_used][addr_0];
                exp_1 = lines[line_used][addr_1];
                check_count += 2;
                if (pr_val[0] !== exp_0)
                begin
                    $display("error: %s reader 0 s=%0d expected %0d actual %0d",
                             test_name, addr_0, exp_0, pr_val[0]);
                    error_count++;
                end
                if (pr_val[1] !== exp_1)
                begin
                    $display("error: %s reader 1 s=%0d expected %0d actual %0d",
                             test_name, addr_1, exp_1, pr_val[1]);
                    error_count++;
                end
                reads_per_line[line_used]++;
            end
            if (i < num_reads)
            begin
                addr_0 = nabp_pkg::s_val_t'(i % nabp_pkg::kLineSize);
                addr_1 = nabp_pkg::s_val_t'(nabp_pkg::kLineSize - 1 - (i % nabp_pkg::kLineSize));
                pr_s_val[0] = addr_0;
                pr_s_val[1] = addr_1;
                line_used = view_line;
            end
        end
    endtask

    task automatic test_reset_state();
        test_name = "test_reset_state";
        for (int c = 0; c <= 5; c++)
        begin
            if (c > 0)
            begin
                @(negedge clk);
            end
            check_count += 2;
            if (hs_fill_done !== 1'b0)
            begin
                $display("error: %s hs_fill_done expected 0 actual %0b", test_name, hs_fill_done);
                error_count++;
            end
            if (hs_s_val !== '0)
            begin
                $display("error: %s hs_s_val expected 0 actual %0d", test_name, hs_s_val);
                error_count++;
            end
        end
    endtask

    task automatic test_fill_timing();
        int   cycles;
        int   exp_s;
        logic done_seen;
        test_name = "test_fill_timing";
        start_fill(0);
        cycles = 0;
        done_seen = 1'b0;
        while (!done_seen && cycles < timeout_cycles)
        begin
            @(negedge clk);
            hs_fill_kick = 1'b0;
            cycles++;
            // source index counts from the first delay cycle and holds at the end
            exp_s = cycles - 1;
            if (exp_s > nabp_pkg::kLineSize - 1)
            begin
                exp_s = nabp_pkg::kLineSize - 1;
            end
            check_count++;
            if (hs_s_val !== nabp_pkg::s_val_t'(exp_s))
            begin
                $display("error: %s hs_s_val in cycle %0d expected %0d actual %0d",
                         test_name, cycles, exp_s, hs_s_val);
                error_count++;
            end
            done_seen = hs_fill_done;
        end
        check_count++;
        if (!done_seen)
        begin
            $display("%s: hs_fill_done never came within %0d cycles", test_name, cycles);
            error_count++;
        end
        else if (cycles != fill_cycles)
        begin
            $display("error: %s cycles to done expected %0d actual %0d",
                     test_name, fill_cycles, cycles);
            error_count++;
        end
    endtask

    task automatic test_read_filled_line();
        test_name = "test_read_filled_line";
        sweep_reads(nabp_pkg::kLineSize);
    endtask

    task automatic test_swap_isolation();
        int cycles;
        int old_before;
        int new_before;
        test_name = "test_swap_isolation";
        old_before = reads_per_line[0];
        new_before = reads_per_line[1];
        fork
            sweep_reads(fill_cycles + 16);
            begin
                start_fill(1);
                wait_fill_done(cycles);
            end
        join
        // reads up to and including the done cycle still see the old line
        check_count += 2;
        if (reads_per_line[0] - old_before != fill_cycles + 1)
        begin
            $display("error: %s reads of old line expected %0d actual %0d",
                     test_name, fill_cycles + 1, reads_per_line[0] - old_before);
            error_count++;
        end
        if (reads_per_line[1] - new_before != 15)
        begin
            $display("error: %s reads of new line expected %0d actual %0d",
                     test_name, 15, reads_per_line[1] - new_before);
            error_count++;
        end
    endtask

    task automatic test_kick_ignored_while_busy();
        int cycles;
        int done_count;
        int first_done;
        test_name = "test_kick_ignored_while_busy";
        start_fill(2);
        done_count = 0;
        first_done = 0;
        for (cycles = 1; cycles <= fill_cycles + 20; cycles++)
        begin
            @(negedge clk);
            // stray kicks in delay, in fill and on the done cycle
            hs_fill_kick = (cycles == 2) || (cycles == 10) || (cycles == 40) ||
                           (cycles == fill_cycles);
            if (hs_fill_done)
            begin
                done_count++;
                if (first_done == 0)
                begin
                    first_done = cycles;
                end
            end
        end
        hs_fill_kick = 1'b0;
        check_count += 3;
        if (done_count != 1)
        begin
            $display("error: %s done pulses expected 1 actual %0d", test_name, done_count);
            error_count++;
        end
        if (first_done != fill_cycles)
        begin
            $display("error: %s cycles to done expected %0d actual %0d",
                     test_name, fill_cycles, first_done);
            error_count++;
        end
        if (hs_s_val !== '0)
        begin
            $display("error: %s hs_s_val after line expected 0 actual %0d", test_name, hs_s_val);
            error_count++;
        end
    endtask

    task automatic test_bank_rotation();
        int cycles;
        test_name = "test_bank_rotation";
        for (int line = 3; line < 6; line++)
        begin
            start_fill(line);
            wait_fill_done(cycles);
            check_count++;
            if (cycles != fill_cycles)
            begin
                $display("error: %s line %0d cycles to done expected %0d actual %0d",
                         test_name, line, fill_cycles, cycles);
                error_count++;
            end
            sweep_reads(nabp_pkg::kLineSize);
        end
    endtask

    initial
    begin
        void'($urandom(32'h281f));
        error_count = 0;
        check_count = 0;
        reset_n = 1'b0;
        hs_fill_kick = 1'b0;
        hs_val = '0;
        fill_line = 0;
        for (int r = 0; r < nabp_pkg::kNumReaders; r++)
        begin
            pr_s_val[r] = '0;
        end
        for (int l = 0; l < max_lines; l++)
        begin
            reads_per_line[l] = 0;
            for (int s = 0; s < nabp_pkg::kLineSize; s++)
            begin
                lines[l][s] = '0;
            end
        end
        repeat (3) @(negedge clk);
        reset_n = 1'b1;

        test_reset_state();
        test_fill_timing();
        test_read_filled_line();
        test_swap_isolation();
        test_kick_ignored_while_busy();
        test_bank_rotation();

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- nabp_filtered_line_top.f
nabp_pkg.sv
dual_port_ram.sv
filtered_ram_bank.sv
filtered_line_filler.sv
processing_read_mux.sv
nabp_filtered_line_top.sv
tb_nabp_filtered_line.sv
